// ==== design/exu_pkg.sv ====
package exu_pkg;

   // machine widths
   localparam int grlen      = 32;
   localparam int reg_addr_w = 5;
   localparam int reg_count  = 32;

   // source register fields in the instruction word
   localparam int inst_rj_lsb = 5;
   localparam int inst_rk_lsb = 10;

   // link address sits one instruction past the branch
   localparam int link_step = 4;

   typedef enum logic {
      class_alu = 1'b0,
      class_bru = 1'b1
   } op_class_t;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_slt  = 4'd2,
      alu_sltu = 4'd3,
      alu_and  = 4'd4,
      alu_or   = 4'd5,
      alu_xor  = 4'd6,
      alu_nor  = 4'd7,
      alu_sll  = 4'd8,
      alu_srl  = 4'd9,
      alu_sra  = 4'd10,
      alu_lui  = 4'd11
   } alu_code_t;

   typedef enum logic [3:0] {
      bru_beq  = 4'd0,
      bru_bne  = 4'd1,
      bru_blt  = 4'd2,
      bru_bge  = 4'd3,
      bru_bltu = 4'd4,
      bru_bgeu = 4'd5,
      bru_b    = 4'd6,
      bru_bl   = 4'd7,
      bru_jirl = 4'd8
   } bru_code_t;

   // one opcode field, meaning depends on op_class
   typedef union packed {
      alu_code_t alu;
      bru_code_t bru;
   } exu_code_u;

   typedef struct packed {
      op_class_t op_class;
      exu_code_u code;
      // operand b from the immediate instead of rk
      logic      src2_imm;
   } exu_op_t;

   // decode to execute register
   typedef struct packed {
      logic                  valid;
      logic [grlen-1:0]      pc;
      exu_op_t               op;
      logic [reg_addr_w-1:0] rd;
      logic                  rf_wen;
      logic [grlen-1:0]      a;
      logic [grlen-1:0]      b;
      logic [grlen-1:0]      imm;
      logic [grlen-1:0]      br_offs;
   } exe_word_t;

   // writeback word, also the register file write port
   typedef struct packed {
      logic [grlen-1:0]      pc;
      logic                  wen;
      logic [reg_addr_w-1:0] rd;
      logic [grlen-1:0]      wdata;
   } wb_word_t;

endpackage

// ==== design/exu_regfile.sv ====
`timescale 1ns/1ps

module exu_regfile
   import exu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [reg_addr_w-1:0] raddr_a,
   input  logic [reg_addr_w-1:0] raddr_b,
   output logic [grlen-1:0]      rdata_a,
   output logic [grlen-1:0]      rdata_b,
   input  wb_word_t              wr
);

   logic [grlen-1:0] regs [reg_count];

   // register 0 never sees wen, ecl clears it at decode
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.wen) begin
         regs[wr.rd] <= wr.wdata;
      end
   end

   // plain combinational reads
   assign rdata_a = regs[raddr_a];
   assign rdata_b = regs[raddr_b];

endmodule

// ==== design/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu
   import exu_pkg::*;
(
   input  logic [grlen-1:0] alu_a,
   input  logic [grlen-1:0] alu_b,
   input  alu_code_t        alu_op,
   output logic [grlen-1:0] alu_res
);

   logic [grlen-1:0] sum;
   logic [grlen-1:0] diff;
   logic             lt_signed;
   logic             lt_unsigned;
   logic [4:0]       shamt;

   assign sum  = alu_a + alu_b;
   assign diff = alu_a - alu_b;

   // less-than flags for slt and sltu
   assign lt_signed   = $signed(alu_a) < $signed(alu_b);
   assign lt_unsigned = alu_a < alu_b;

   // shift amount from the low five bits of b
   assign shamt = alu_b[4:0];

   always_comb begin
      case (alu_op)
         alu_add: begin
            alu_res = sum;
         end
         alu_sub: begin
            alu_res = diff;
         end
         alu_slt: begin
            alu_res = {{(grlen-1){1'b0}}, lt_signed};
         end
         alu_sltu: begin
            alu_res = {{(grlen-1){1'b0}}, lt_unsigned};
         end
         alu_and: begin
            alu_res = alu_a & alu_b;
         end
         alu_or: begin
            alu_res = alu_a | alu_b;
         end
         alu_xor: begin
            alu_res = alu_a ^ alu_b;
         end
         alu_nor: begin
            alu_res = ~(alu_a | alu_b);
         end
         alu_sll: begin
            alu_res = alu_a << shamt;
         end
         alu_srl: begin
            alu_res = alu_a >> shamt;
         end
         alu_sra: begin
            alu_res = $unsigned($signed(alu_a) >>> shamt);
         end
         // b already holds the shifted immediate
         alu_lui: begin
            alu_res = alu_b;
         end
         default: begin
            alu_res = '0;
         end
      endcase
   end

endmodule

// ==== design/exu_bru.sv ====
`timescale 1ns/1ps

module exu_bru
   import exu_pkg::*;
(
   input  exe_word_t        exe,
   output logic [grlen-1:0] bru_target,
   output logic             bru_taken,
   output logic [grlen-1:0] bru_link
);

   logic cond;
   logic is_bru;

   assign is_bru = (exe.op.op_class == class_bru);

   // branch condition on the two register operands
   always_comb begin
      case (exe.op.code.bru)
         bru_beq:  cond = (exe.a == exe.b);
         bru_bne:  cond = (exe.a != exe.b);
         bru_blt:  cond = ($signed(exe.a) < $signed(exe.b));
         bru_bge:  cond = ($signed(exe.a) >= $signed(exe.b));
         bru_bltu: cond = (exe.a < exe.b);
         bru_bgeu: cond = (exe.a >= exe.b);
         bru_b,
         bru_bl,
         bru_jirl: cond = 1'b1;
         default:  cond = 1'b0;
      endcase
   end

   assign bru_taken = exe.valid && is_bru && cond;

   // jirl is register relative, the rest pc relative
   always_comb begin
      if (exe.op.code.bru == bru_jirl) begin
         bru_target = exe.a + exe.br_offs;
      end else begin
         bru_target = exe.pc + exe.br_offs;
      end
   end

   assign bru_link = exe.pc + link_step;

endmodule

// ==== design/exu_ecl.sv ====
`timescale 1ns/1ps

module exu_ecl
   import exu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  ifu_exu_valid_d,
   input  logic [grlen-1:0]      ifu_exu_pc_d,
   input  logic [31:0]           ifu_exu_inst_d,
   input  exu_op_t               ifu_exu_op_d,
   input  logic                  ifu_exu_rf_wen_d,
   input  logic [reg_addr_w-1:0] ifu_exu_rf_target_d,
   input  logic [grlen-1:0]      ifu_exu_imm_shifted_d,
   input  logic [grlen-1:0]      ifu_exu_br_offs,

   output logic [reg_addr_w-1:0] rf_raddr_a,
   output logic [reg_addr_w-1:0] rf_raddr_b,
   input  logic [grlen-1:0]      rf_rdata_a,
   input  logic [grlen-1:0]      rf_rdata_b,

   output logic [grlen-1:0]      alu_a,
   output logic [grlen-1:0]      alu_b,
   output alu_code_t             alu_op,
   input  logic [grlen-1:0]      alu_res,

   output exe_word_t             exe,
   input  logic [grlen-1:0]      bru_target,
   input  logic                  bru_taken,
   input  logic [grlen-1:0]      bru_link,

   output logic                  exu_ifu_br_taken_e,
   output logic [grlen-1:0]      exu_ifu_brpc_e,
   output wb_word_t              wb
);

   logic [reg_addr_w-1:0] rj_d;
   logic [reg_addr_w-1:0] rk_d;
   logic [grlen-1:0]      src_a_d;
   logic [grlen-1:0]      src_b_d;
   logic [grlen-1:0]      res_e;
   exe_word_t             exe_d;
   wb_word_t              wb_d;

   // newest value wins: execute, then writeback, then the file
   function automatic logic [grlen-1:0] bypass(
      input logic [reg_addr_w-1:0] src,
      input logic [grlen-1:0]      rf_val,
      input exe_word_t             ex,
      input logic [grlen-1:0]      ex_res,
      input wb_word_t              w
   );
      logic [grlen-1:0] val;
      if (ex.valid && ex.rf_wen && ex.rd == src) begin
         val = ex_res;
      end else if (w.wen && w.rd == src) begin
         val = w.wdata;
      end else begin
         val = rf_val;
      end
      return val;
   endfunction

   // decode stage
   assign rj_d       = ifu_exu_inst_d[inst_rj_lsb +: reg_addr_w];
   assign rk_d       = ifu_exu_inst_d[inst_rk_lsb +: reg_addr_w];
   assign rf_raddr_a = rj_d;
   assign rf_raddr_b = rk_d;

   assign src_a_d = bypass(rj_d, rf_rdata_a, exe, res_e, wb);
   assign src_b_d = bypass(rk_d, rf_rdata_b, exe, res_e, wb);

   always_comb begin
      // taken branch in execute kills the decode slot
      exe_d.valid   = ifu_exu_valid_d && !exu_ifu_br_taken_e;
      exe_d.pc      = ifu_exu_pc_d;
      exe_d.op      = ifu_exu_op_d;
      exe_d.rd      = ifu_exu_rf_target_d;
      // r0 is hardwired, drop its write here
      exe_d.rf_wen  = ifu_exu_rf_wen_d && (ifu_exu_rf_target_d != '0);
      exe_d.a       = src_a_d;
      exe_d.b       = ifu_exu_op_d.src2_imm ? ifu_exu_imm_shifted_d : src_b_d;
      exe_d.imm     = ifu_exu_imm_shifted_d;
      exe_d.br_offs = ifu_exu_br_offs;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exe <= '0;
      end else begin
         exe <= exe_d;
      end
   end

   // execute stage
   assign alu_a  = exe.a;
   assign alu_b  = exe.b;
   assign alu_op = exe.op.code.alu;

   assign res_e = (exe.op.op_class == class_bru) ? bru_link : alu_res;

   always_comb begin
      wb_d.pc    = exe.pc;
      wb_d.wen   = exe.valid && exe.rf_wen;
      wb_d.rd    = exe.rd;
      wb_d.wdata = res_e;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb <= '0;
      end else begin
         wb <= wb_d;
      end
   end

   // redirect goes straight back to fetch
   assign exu_ifu_br_taken_e = bru_taken;
   assign exu_ifu_brpc_e     = bru_target;

endmodule

// ==== design/cpu7_exu.sv ====
`timescale 1ns/1ps

module cpu7_exu
   import exu_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  ifu_exu_valid_d,
   input  logic [grlen-1:0]      ifu_exu_pc_d,
   input  logic [31:0]           ifu_exu_inst_d,
   input  exu_op_t               ifu_exu_op_d,
   input  logic                  ifu_exu_rf_wen_d,
   input  logic [reg_addr_w-1:0] ifu_exu_rf_target_d,
   input  logic [grlen-1:0]      ifu_exu_imm_shifted_d,
   input  logic [grlen-1:0]      ifu_exu_br_offs,

   output logic                  exu_ifu_br_taken_e,
   output logic [grlen-1:0]      exu_ifu_brpc_e,
   output wb_word_t              debug_wb
);

   logic [reg_addr_w-1:0] rf_raddr_a;
   logic [reg_addr_w-1:0] rf_raddr_b;
   logic [grlen-1:0]      rf_rdata_a;
   logic [grlen-1:0]      rf_rdata_b;

   logic [grlen-1:0]      alu_a;
   logic [grlen-1:0]      alu_b;
   alu_code_t             alu_op;
   logic [grlen-1:0]      alu_res;

   exe_word_t             exe;
   logic [grlen-1:0]      bru_target;
   logic                  bru_taken;
   logic [grlen-1:0]      bru_link;

   // writeback word doubles as the debug port
   exu_ecl ecl (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .ifu_exu_valid_d       (ifu_exu_valid_d),
      .ifu_exu_pc_d          (ifu_exu_pc_d),
      .ifu_exu_inst_d        (ifu_exu_inst_d),
      .ifu_exu_op_d          (ifu_exu_op_d),
      .ifu_exu_rf_wen_d      (ifu_exu_rf_wen_d),
      .ifu_exu_rf_target_d   (ifu_exu_rf_target_d),
      .ifu_exu_imm_shifted_d (ifu_exu_imm_shifted_d),
      .ifu_exu_br_offs       (ifu_exu_br_offs),
      .rf_raddr_a            (rf_raddr_a),
      .rf_raddr_b            (rf_raddr_b),
      .rf_rdata_a            (rf_rdata_a),
      .rf_rdata_b            (rf_rdata_b),
      .alu_a                 (alu_a),
      .alu_b                 (alu_b),
      .alu_op                (alu_op),
      .alu_res               (alu_res),
      .exe                   (exe),
      .bru_target            (bru_target),
      .bru_taken             (bru_taken),
      .bru_link              (bru_link),
      .exu_ifu_br_taken_e    (exu_ifu_br_taken_e),
      .exu_ifu_brpc_e        (exu_ifu_brpc_e),
      .wb                    (debug_wb)
   );

   exu_regfile registers (
      .clk     (clk),
      .rst_n   (rst_n),
      .raddr_a (rf_raddr_a),
      .raddr_b (rf_raddr_b),
      .rdata_a (rf_rdata_a),
      .rdata_b (rf_rdata_b),
      .wr      (debug_wb)
   );

   exu_alu alu (
      .alu_a   (alu_a),
      .alu_b   (alu_b),
      .alu_op  (alu_op),
      .alu_res (alu_res)
   );

   exu_bru bru (
      .exe        (exe),
      .bru_target (bru_target),
      .bru_taken  (bru_taken),
      .bru_link   (bru_link)
   );

endmodule

// ==== bench/exu_tb.sv ====
`timescale 1ns/1ps

module exu_tb
   import exu_pkg::*;
();

   localparam int n_warm        = 40;
   localparam int n_sweep       = 36;
   localparam int n_mix         = 80;
   localparam int n_issued      = n_warm + n_sweep + n_mix;
   localparam int timeout_limit = 2 * (8 + n_issued + 4);

   // what the DUT should show for one issued slot
   typedef struct packed {
      logic             taken;
      logic [grlen-1:0] brpc;
      wb_word_t         wb;
   } expect_t;

   logic                  clk;
   logic                  rst_n;
   logic                  ifu_exu_valid_d;
   logic [grlen-1:0]      ifu_exu_pc_d;
   logic [31:0]           ifu_exu_inst_d;
   exu_op_t               ifu_exu_op_d;
   logic                  ifu_exu_rf_wen_d;
   logic [reg_addr_w-1:0] ifu_exu_rf_target_d;
   logic [grlen-1:0]      ifu_exu_imm_shifted_d;
   logic [grlen-1:0]      ifu_exu_br_offs;
   logic                  exu_ifu_br_taken_e;
   logic [grlen-1:0]      exu_ifu_brpc_e;
   wb_word_t              debug_wb;

   // reference model state kept in program order
   logic [grlen-1:0] model_regs [reg_count];
   logic [grlen-1:0] model_pc;
   logic             last_taken;
   logic [grlen-1:0] last_target;
   logic [31:0]      rng_state = 32'd63;
   int               cycle = 0;

   expect_t  exp_d;
   expect_t  exp_e;
   wb_word_t exp_w;

   cpu7_exu uut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   task automatic end_failed();
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("Error at %0t: %s expected %h, actual %h", $time, sig, expected, actual);
      end_failed();
   endtask

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= timeout_limit) begin
         $display("timeout: run still going after %0d cycles", cycle);
         end_failed();
      end
   end

   // expected values follow the instruction down the pipe
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exp_e <= '0;
         exp_w <= '0;
      end else begin
         exp_e <= exp_d;
         exp_w <= exp_e.wb;
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic signed_less(input logic [31:0] x, input logic [31:0] y);
      return (x[31] != y[31]) ? x[31] : (x < y);
   endfunction

   function automatic logic [31:0] alu_model(input alu_code_t code, input logic [31:0] x,
                                             input logic [31:0] y);
      logic [4:0] sh;
      sh = y[4:0];
      case (code)
         alu_add:  return x + y;
         alu_sub:  return x - y;
         alu_slt:  return 32'(signed_less(x, y));
         alu_sltu: return 32'(x < y);
         alu_and:  return x & y;
         alu_or:   return x | y;
         alu_xor:  return x ^ y;
         alu_nor:  return ~(x | y);
         alu_sll:  return x << sh;
         alu_srl:  return x >> sh;
         // sign fill by hand
         alu_sra:  return (x >> sh) | (x[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
         alu_lui:  return y;
         default:  return 32'h0;
      endcase
   endfunction

   function automatic logic branch_cond(input bru_code_t code, input logic [31:0] x,
                                        input logic [31:0] y);
      case (code)
         bru_beq:  return x == y;
         bru_bne:  return x != y;
         bru_blt:  return signed_less(x, y);
         bru_bge:  return !signed_less(x, y);
         bru_bltu: return x < y;
         bru_bgeu: return !(x < y);
         default:  return 1'b1;
      endcase
   endfunction

   // model one slot and drive it at the next edge
   task automatic issue(input logic is_bru, input logic [3:0] code, input logic [4:0] rj,
                        input logic [4:0] rk, input logic [4:0] rd, input logic wr_en,
                        input logic use_imm, input logic [31:0] imm, input logic [31:0] offs);
      exu_op_t     op;
      expect_t     ex;
      logic [31:0] inst;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] cur_pc;
      logic        cond;
      logic        squash;
      cur_pc = model_pc;
      squash = last_taken;
      a = model_regs[rj];
      b = use_imm ? imm : model_regs[rk];
      op.op_class = is_bru ? class_bru : class_alu;
      op.code.alu = alu_code_t'(code);
      op.src2_imm = use_imm;
      inst = next_rand();
      inst[inst_rj_lsb +: reg_addr_w] = rj;
      inst[inst_rk_lsb +: reg_addr_w] = rk;
      cond = is_bru && branch_cond(bru_code_t'(code), a, b);
      ex.taken = !squash && cond;
      ex.brpc = ((code == bru_jirl) ? a : cur_pc) + offs;
      ex.wb.pc = cur_pc;
      ex.wb.wen = !squash && wr_en && (rd != 5'd0);
      ex.wb.rd = rd;
      ex.wb.wdata = is_bru ? cur_pc + 32'd4 : alu_model(alu_code_t'(code), a, b);
      if (ex.wb.wen) begin
         model_regs[rd] = ex.wb.wdata;
      end
      // the slot after a squashed one fetches the branch target
      model_pc = squash ? last_target : cur_pc + 32'd4;
      last_taken = ex.taken;
      last_target = ex.brpc;
      @(posedge clk);
      ifu_exu_valid_d       <= 1'b1;
      ifu_exu_pc_d          <= cur_pc;
      ifu_exu_inst_d        <= inst;
      ifu_exu_op_d          <= op;
      ifu_exu_rf_wen_d      <= wr_en;
      ifu_exu_rf_target_d   <= rd;
      ifu_exu_imm_shifted_d <= imm;
      ifu_exu_br_offs       <= offs;
      exp_d                 <= ex;
   endtask

   task automatic idle();
      @(posedge clk);
      ifu_exu_valid_d <= 1'b0;
      exp_d           <= '0;
      last_taken = 1'b0;
   endtask

   // small register range keeps dependencies dense
   task automatic issue_random_alu();
      logic [31:0] r;
      r = next_rand();
      issue(1'b0, r[3:0] % 4'd12, {2'b00, r[6:4]}, {2'b00, r[9:7]}, {2'b00, r[12:10]},
            r[15:13] != 3'd0, r[16], next_rand(), 32'h0);
   endtask

   task automatic issue_random_bru(input logic [3:0] code, input logic same_src);
      logic [31:0] r;
      logic [4:0]  rj;
      r = next_rand();
      rj = {2'b00, r[2:0]};
      issue(1'b1, code, rj, same_src ? rj : {2'b00, r[5:3]}, {2'b00, r[8:6]},
            (code == bru_bl) || (code == bru_jirl), 1'b0, next_rand(),
            {{14{r[24]}}, r[24:9], 2'b00});
   endtask

   a_rst_taken: assert property (@(posedge clk) rst_n || cycle < 2 || !exu_ifu_br_taken_e)
      else report_mismatch("exu_ifu_br_taken_e", 32'h0, 32'($sampled(exu_ifu_br_taken_e)));
   a_rst_wen: assert property (@(posedge clk) rst_n || cycle < 2 || !debug_wb.wen)
      else report_mismatch("debug_wb.wen", 32'h0, 32'($sampled(debug_wb.wen)));
   a_taken: assert property (@(posedge clk) disable iff (!rst_n)
         exu_ifu_br_taken_e == exp_e.taken)
      else report_mismatch("exu_ifu_br_taken_e", 32'($sampled(exp_e.taken)),
                           32'($sampled(exu_ifu_br_taken_e)));
   a_brpc: assert property (@(posedge clk) disable iff (!rst_n)
         !exp_e.taken || exu_ifu_brpc_e == exp_e.brpc)
      else report_mismatch("exu_ifu_brpc_e", $sampled(exp_e.brpc), $sampled(exu_ifu_brpc_e));
   a_wen: assert property (@(posedge clk) disable iff (!rst_n) debug_wb.wen == exp_w.wen)
      else report_mismatch("debug_wb.wen", 32'($sampled(exp_w.wen)),
                           32'($sampled(debug_wb.wen)));
   a_pc: assert property (@(posedge clk) disable iff (!rst_n)
         !exp_w.wen || debug_wb.pc == exp_w.pc)
      else report_mismatch("debug_wb.pc", $sampled(exp_w.pc), $sampled(debug_wb.pc));
   a_rd: assert property (@(posedge clk) disable iff (!rst_n)
         !exp_w.wen || debug_wb.rd == exp_w.rd)
      else report_mismatch("debug_wb.rd", 32'($sampled(exp_w.rd)), 32'($sampled(debug_wb.rd)));
   a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
         !exp_w.wen || debug_wb.wdata == exp_w.wdata)
      else report_mismatch("debug_wb.wdata", $sampled(exp_w.wdata), $sampled(debug_wb.wdata));

   initial begin
      logic [31:0] r;
      for (int i = 0; i < reg_count; i++) begin
         model_regs[i] = '0;
      end
      model_pc              = 32'h1c00_0000;
      last_taken            = 1'b0;
      last_target           = '0;
      exp_d                 = '0;
      rst_n                 = 1'b0;
      ifu_exu_valid_d       = 1'b0;
      ifu_exu_pc_d          = '0;
      ifu_exu_inst_d        = '0;
      ifu_exu_op_d          = '0;
      ifu_exu_rf_wen_d      = 1'b0;
      ifu_exu_rf_target_d   = '0;
      ifu_exu_imm_shifted_d = '0;
      ifu_exu_br_offs       = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      // first reads after reset see an all-zero file
      for (int i = 0; i < n_warm; i++) begin
         issue_random_alu();
      end
      // each branch code with equal sources on the first pass
      // the alu op right behind a taken branch gets squashed
      for (int rep = 0; rep < 2; rep++) begin
         for (int c = 0; c < 9; c++) begin
            issue_random_bru(4'(c), rep == 0);
            issue_random_alu();
         end
      end
      for (int i = 0; i < n_mix; i++) begin
         r = next_rand();
         if (r[2:0] == 3'd0) begin
            issue_random_bru(r[7:4] % 4'd9, r[8]);
         end else begin
            issue_random_alu();
         end
      end
      repeat (4) idle();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== vlog.f ====
design/exu_pkg.sv
design/exu_regfile.sv
design/exu_alu.sv
design/exu_bru.sv
design/exu_ecl.sv
design/cpu7_exu.sv
bench/exu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu7_exu

sources:
  - files:
      - design/exu_pkg.sv
      - design/exu_regfile.sv
      - design/exu_alu.sv
      - design/exu_bru.sv
      - design/exu_ecl.sv
      - design/cpu7_exu.sv
  - target: test
    files:
      - bench/exu_tb.sv
